// File: filelist.f
+incdir+design
design/dw_pkg.sv
design/dw_shift_ctrl.sv
design/dw_unit_lane.sv
design/dw_out_packer.sv
design/dw_serializer.sv
tests/dw_monitor.sv
tests/dw_serializer_chk.sv
tests/dw_serializer_tb.sv

// File: Makefile
# Verilator build and run for the depthwise output serializer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
	  --top-module dw_serializer_tb \
	  -f filelist.f \
	  -Mdir obj_dir -o sim

# Pass only when the testbench prints its pass line
run: compile
	@out=$$(./obj_dir/sim +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: tests/dw_serializer_tb.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_serializer_tb;

  localparam int TOTAL_BEATS = 5 + 8 + 10 + 20 + 40;

  logic                                           aclk = 1'b0;
  logic                                           i_rst_n;
  dw_pkg::word_t [`DW_MEMBERS-1:0][`DW_UNITS-1:0] i_data;
  logic [`DW_MEMBERS-1:0]                         i_keep;
  dw_pkg::cfg_e                                   i_cfg;
  logic                                           i_valid;
  logic                                           i_last;
  logic                                           i_m_ready = 1'b1;
  logic                                           o_s_ready;
  dw_pkg::word_t [`DW_UNITS-1:0]                  o_data;
  dw_pkg::member_idx_t                            o_member;
  dw_pkg::cfg_e                                   o_cfg;
  logic                                           o_valid;
  logic                                           o_last;

  integer seed       = 32'hecf9;
  integer ready_seed = 32'hecf9 ^ 32'h0000_5a5a;  // Own stream for back-pressure
  logic   bp_on      = 1'b0;
  int     err_mark   = 0;
  int     n_pass     = 0;
  int     n_fail     = 0;

  always #4 aclk = ~aclk;

  always @(negedge aclk) begin
    i_m_ready = bp_on ? (($random(ready_seed) & 1) != 0) : 1'b1;
  end

  dw_serializer u_dut (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_data    (i_data),
    .i_keep    (i_keep),
    .i_cfg     (i_cfg),
    .i_valid   (i_valid),
    .i_last    (i_last),
    .i_m_ready (i_m_ready),
    .o_s_ready (o_s_ready),
    .o_data    (o_data),
    .o_member  (o_member),
    .o_cfg     (o_cfg),
    .o_valid   (o_valid),
    .o_last    (o_last)
  );

  dw_monitor u_mon (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_s_ready (o_s_ready),
    .i_valid   (o_valid),
    .i_ready   (i_m_ready),
    .i_data    (o_data),
    .i_member  (o_member),
    .i_cfg     (o_cfg),
    .i_last    (o_last)
  );

  // Member m is produced when m % (kw + sw - 1) == kw + sw - 2, K1S1 takes the last one
  function automatic int dw_expect(input dw_pkg::cfg_e cfg,
                                   input logic [`DW_MEMBERS-1:0] keep,
                                   input logic last,
                                   input dw_pkg::word_t [`DW_MEMBERS-1:0][`DW_UNITS-1:0] data,
                                   output int mem_list [`DW_SLOTS],
                                   output dw_pkg::word_t [`DW_UNITS-1:0] word_list [`DW_SLOTS],
                                   output logic last_list [`DW_SLOTS]);
    int j;
    int n;
    n = 0;
    for (int i = 0; i < `DW_SLOTS; i++) begin
      mem_list[i]  = 0;
      word_list[i] = '0;
      last_list[i] = 1'b0;
    end
    case (cfg)
      dw_pkg::K3S1:  j = 3 + 1 - 1;
      dw_pkg::K5S1:  j = 5 + 1 - 1;
      dw_pkg::K7S2:  j = 7 + 2 - 1;
      dw_pkg::K11S4: j = 11 + 4 - 1;
      default:       j = 0;
    endcase
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      if ((j == 0 && m == `DW_MEMBERS - 1) || (j != 0 && m % j == j - 1)) begin
        if (!keep[m]) break;  // Output stops at the first dropped member
        mem_list[n]  = m;
        word_list[n] = data[m];
        n++;
      end
    end
    if (n > 0) last_list[n-1] = last;
    return n;
  endfunction

  function automatic int picked_count(input dw_pkg::cfg_e cfg);
    int                            ml [`DW_SLOTS];
    dw_pkg::word_t [`DW_UNITS-1:0] wl [`DW_SLOTS];
    logic                          ll [`DW_SLOTS];
    return dw_expect(cfg, '1, 1'b0, '0, ml, wl, ll);
  endfunction

  // Random beat with the first kept picked members set, queued for the monitor
  task automatic send_beat(input dw_pkg::cfg_e cfg, input int kept, input logic last);
    dw_pkg::word_t [`DW_MEMBERS-1:0][`DW_UNITS-1:0] data;
    logic [`DW_MEMBERS-1:0]                         keep;
    int                                             ml [`DW_SLOTS];
    dw_pkg::word_t [`DW_UNITS-1:0]                  wl [`DW_SLOTS];
    logic                                           ll [`DW_SLOTS];
    int                                             n;
    for (int m = 0; m < `DW_MEMBERS; m++) begin
      for (int u = 0; u < `DW_UNITS; u++) begin
        data[m][u] = dw_pkg::word_t'($random(seed));
      end
      keep[m] = ($random(seed) & 1) != 0;  // Don't care off the window
    end
    n = dw_expect(cfg, '1, last, data, ml, wl, ll);
    for (int i = 0; i < n; i++) begin
      keep[ml[i]] = (i < kept);
    end
    n = dw_expect(cfg, keep, last, data, ml, wl, ll);
    for (int i = 0; i < n; i++) begin
      u_mon.push(dw_pkg::member_idx_t'(ml[i]), wl[i], cfg, ll[i]);
    end
    @(negedge aclk);
    i_data  = data;
    i_keep  = keep;
    i_cfg   = cfg;
    i_last  = last;
    i_valid = 1'b1;
    while (!o_s_ready) @(negedge aclk);
    @(posedge aclk);
  endtask

  task automatic send_random(input logic all_kept);
    int           r;
    int           kept;
    logic         last;
    dw_pkg::cfg_e cfg;
    r    = $unsigned($random(seed)) % 5;
    cfg  = dw_pkg::cfg_e'(r[2:0]);
    kept = all_kept ? `DW_SLOTS : 1 + ($unsigned($random(seed)) % picked_count(cfg));
    last = ($random(seed) & 1) != 0;
    send_beat(cfg, kept, last);
  endtask

  task automatic set_backpressure(input logic on);
    @(posedge aclk);
    bp_on = on;
  endtask

  // Drop valid, wait for the DUT to go idle, then grade the test
  task automatic finish_test(input string name);
    int errs;
    @(negedge aclk);
    i_valid = 1'b0;
    i_last  = 1'b0;
    while (!o_s_ready) @(negedge aclk);
    u_mon.check_drained();
    errs = u_mon.err_cnt + u_dut.u_chk.fail_total();
    if (errs == err_mark) begin
      $display("test %s: passed", name);
      n_pass++;
    end else begin
      $display("test %s: failed with %0d errors", name, errs - err_mark);
      n_fail++;
    end
    err_mark = errs;
  endtask

  initial begin
    #(TOTAL_BEATS * 40 * 8);
    $display("Watchdog expired at %0t ns, the DUT stopped making progress", $time);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int cnt;
    i_rst_n = 1'b0;
    i_data  = '0;
    i_keep  = '0;
    i_cfg   = dw_pkg::K1S1;
    i_valid = 1'b0;
    i_last  = 1'b0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    i_rst_n = 1'b1;

    @(negedge aclk);
    u_mon.check_idle();
    finish_test("reset state");

    for (int c = 0; c < 5; c++) begin
      send_beat(dw_pkg::cfg_e'(c), `DW_SLOTS, 1'b0);
    end
    finish_test("all members kept");

    for (int c = 1; c < 5; c++) begin
      cnt = picked_count(dw_pkg::cfg_e'(c));
      send_beat(dw_pkg::cfg_e'(c), 1, 1'b1);
      send_beat(dw_pkg::cfg_e'(c), (cnt > 1) ? cnt - 1 : 1, 1'b0);
    end
    finish_test("partial keep");

    for (int i = 0; i < 10; i++) begin
      cnt = picked_count(dw_pkg::cfg_e'(i % 5));
      send_beat(dw_pkg::cfg_e'(i % 5), 1 + (i % cnt), (i % 2) == 0);
    end
    finish_test("last flag");

    set_backpressure(1'b1);
    repeat (20) send_random(1'b1);
    finish_test("back-pressure");
    set_backpressure(1'b0);

    repeat (40) send_random(1'b0);
    finish_test("back-to-back random");

    $display("Summary: %0d tests passed, %0d failed, %0d output beats checked",
             n_pass, n_fail, u_mon.beat_cnt);
    if (n_fail == 0 && err_mark == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tests/dw_serializer_chk.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_serializer_chk (
  input  logic                          aclk,
  input  logic                          i_rst_n,
  input  logic                          i_in_valid,
  input  logic [`DW_MEMBERS-1:0]        i_in_keep,
  input  dw_pkg::cfg_e                  i_in_cfg,
  input  logic                          i_s_ready,
  input  logic                          i_out_valid,
  input  logic                          i_m_ready,
  input  dw_pkg::word_t [`DW_UNITS-1:0] i_out_data,
  input  dw_pkg::member_idx_t           i_out_member,
  input  logic                          i_out_last
);

  logic [`DW_SLOTS-1:0] picked_keep;
  int                   excl_fail   = 0;
  int                   stable_fail = 0;
  int                   keep_fail   = 0;

  // Keep bits of the picked members, slot order
  always_comb begin
    dw_pkg::member_idx_t src;
    logic                used;
    for (int s = 0; s < `DW_SLOTS; s++) begin
      src            = dw_pkg::slot_src(i_in_cfg, dw_pkg::slot_idx_t'(s), used);
      picked_keep[s] = used && i_in_keep[src];
    end
  end

  function automatic int fail_total();
    return excl_fail + stable_fail + keep_fail;
  endfunction

  a_ready_valid_excl: assert property (@(posedge aclk) disable iff (!i_rst_n)
    !(i_s_ready && i_out_valid))
    else begin
      $error("o_s_ready and o_valid high in the same cycle");
      excl_fail++;
    end

  a_hold_under_stall: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (i_out_valid && !i_m_ready) |=> (i_out_valid && $stable(i_out_data) &&
                                     $stable(i_out_member) && $stable(i_out_last)))
    else begin
      $error("output beat changed while stalled");
      stable_fail++;
    end

  // First picked member kept, kept ones form a prefix
  a_keep_prefix: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (i_in_valid && i_s_ready) |-> (picked_keep[0] &&
                                   ((picked_keep & (picked_keep + 1'b1)) == '0)))
    else begin
      $error("input keep bits of picked members are not a prefix");
      keep_fail++;
    end

endmodule

bind dw_serializer dw_serializer_chk u_chk (
  .aclk         (aclk),
  .i_rst_n      (i_rst_n),
  .i_in_valid   (i_valid),
  .i_in_keep    (i_keep),
  .i_in_cfg     (i_cfg),
  .i_s_ready    (o_s_ready),
  .i_out_valid  (o_valid),
  .i_m_ready    (i_m_ready),
  .i_out_data   (o_data),
  .i_out_member (o_member),
  .i_out_last   (o_last)
);

// File: tests/dw_monitor.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_monitor (
  input  logic                          aclk,
  input  logic                          i_rst_n,
  input  logic                          i_s_ready,
  input  logic                          i_valid,
  input  logic                          i_ready,
  input  dw_pkg::word_t [`DW_UNITS-1:0] i_data,
  input  dw_pkg::member_idx_t           i_member,
  input  dw_pkg::cfg_e                  i_cfg,
  input  logic                          i_last
);

  // Expected output beats, oldest first
  dw_pkg::member_idx_t           exp_member_q[$];
  dw_pkg::word_t [`DW_UNITS-1:0] exp_data_q[$];
  dw_pkg::cfg_e                  exp_cfg_q[$];
  logic                          exp_last_q[$];

  int err_cnt  = 0;
  int beat_cnt = 0;

  task automatic push(input dw_pkg::member_idx_t member,
                      input dw_pkg::word_t [`DW_UNITS-1:0] data,
                      input dw_pkg::cfg_e cfg,
                      input logic last);
    exp_member_q.push_back(member);
    exp_data_q.push_back(data);
    exp_cfg_q.push_back(cfg);
    exp_last_q.push_back(last);
  endtask

  task automatic check_idle();
    if (i_s_ready !== 1'b1 || i_valid !== 1'b0 || i_last !== 1'b0) begin
      $display("[FAIL] %0t ns: idle outputs s_ready=%b valid=%b last=%b, want 1 0 0",
               $time, i_s_ready, i_valid, i_last);
      err_cnt++;
    end
  endtask

  // Called once the DUT is idle again
  task automatic check_drained();
    if (exp_member_q.size() != 0) begin
      $display("Missing output: %0d expected beats never came out of the DUT (at %0t ns)",
               exp_member_q.size(), $time);
      err_cnt++;
      exp_member_q.delete();
      exp_data_q.delete();
      exp_cfg_q.delete();
      exp_last_q.delete();
    end
  endtask

  always @(posedge aclk) begin
    dw_pkg::member_idx_t           e_member;
    dw_pkg::word_t [`DW_UNITS-1:0] e_data;
    dw_pkg::cfg_e                  e_cfg;
    logic                          e_last;
    if (i_rst_n && i_valid && i_ready) begin
      if (exp_member_q.size() == 0) begin
        $display("Extra output beat at %0t ns: member %0d came out with nothing expected",
                 $time, i_member);
        err_cnt++;
      end else begin
        e_member = exp_member_q.pop_front();
        e_data   = exp_data_q.pop_front();
        e_cfg    = exp_cfg_q.pop_front();
        e_last   = exp_last_q.pop_front();
        if (i_member !== e_member || i_data !== e_data || i_cfg !== e_cfg ||
            i_last !== e_last) begin
          $display("[FAIL] %0t ns: want member %0d data %h cfg %0d last %b, got %0d %h %0d %b",
                   $time, e_member, e_data, e_cfg, e_last,
                   i_member, i_data, i_cfg, i_last);
          err_cnt++;
        end
      end
      beat_cnt++;
    end
  end

endmodule

// File: design/dw_serializer.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_serializer (
  input  logic                                             aclk,
  input  logic                                             i_rst_n,
  input  dw_pkg::word_t [`DW_MEMBERS-1:0][`DW_UNITS-1:0]   i_data,
  input  logic [`DW_MEMBERS-1:0]                           i_keep,
  input  dw_pkg::cfg_e                                     i_cfg,
  input  logic                                             i_valid,
  input  logic                                             i_last,
  input  logic                                             i_m_ready,
  output logic                                             o_s_ready,
  output dw_pkg::word_t [`DW_UNITS-1:0]                    o_data,
  output dw_pkg::member_idx_t                              o_member,
  output dw_pkg::cfg_e                                     o_cfg,
  output logic                                             o_valid,
  output logic                                             o_last
);

  dw_pkg::word_t [`DW_UNITS-1:0][`DW_MEMBERS-1:0] col;
  dw_pkg::word_t [`DW_UNITS-1:0]                  lane_word;
  logic                                           load;
  logic                                           shift;

  dw_shift_ctrl u_ctrl (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_valid   (i_valid),
    .i_last    (i_last),
    .i_keep    (i_keep),
    .i_cfg     (i_cfg),
    .i_m_ready (i_m_ready),
    .o_s_ready (o_s_ready),
    .o_valid   (o_valid),
    .o_last    (o_last),
    .o_cfg     (o_cfg),
    .o_load    (load),
    .o_shift   (shift)
  );

  for (genvar u = 0; u < `DW_UNITS; u++) begin : g_lane
    // Column of unit u across all members
    for (genvar m = 0; m < `DW_MEMBERS; m++) begin : g_col
      assign col[u][m] = i_data[m][u];
    end

    dw_unit_lane u_lane (
      .aclk    (aclk),
      .i_rst_n (i_rst_n),
      .i_col   (col[u]),
      .i_cfg   (o_cfg),
      .i_load  (load),
      .i_shift (shift),
      .o_word  (lane_word[u])
    );
  end

  dw_out_packer u_pack (
    .aclk     (aclk),
    .i_rst_n  (i_rst_n),
    .i_words  (lane_word),
    .i_cfg    (o_cfg),
    .i_load   (load),
    .i_shift  (shift),
    .o_data   (o_data),
    .o_member (o_member)
  );

endmodule

// File: design/dw_out_packer.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_out_packer (
  input  logic                             aclk,
  input  logic                             i_rst_n,
  input  dw_pkg::word_t [`DW_UNITS-1:0]    i_words,
  input  dw_pkg::cfg_e                     i_cfg,
  input  logic                             i_load,
  input  logic                             i_shift,
  output dw_pkg::word_t [`DW_UNITS-1:0]    o_data,
  output dw_pkg::member_idx_t              o_member
);

  dw_pkg::slot_idx_t   cnt_q;
  dw_pkg::member_idx_t src;
  logic                used;

  // One word per lane, unit 0 in the low word
  always_comb begin
    for (int u = 0; u < `DW_UNITS; u++) begin
      o_data[u] = i_words[u];
    end
  end

  // Slot currently sitting at the output
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (i_load) begin
      cnt_q <= '0;
    end else if (i_shift && used) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_comb begin
    src = dw_pkg::slot_src(i_cfg, cnt_q, used);
  end

  assign o_member = src;  // Column of the beat on o_data

endmodule

// File: design/dw_unit_lane.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_unit_lane (
  input  logic                                 aclk,
  input  logic                                 i_rst_n,
  input  dw_pkg::word_t [`DW_MEMBERS-1:0]      i_col,
  input  dw_pkg::cfg_e                         i_cfg,
  input  logic                                 i_load,
  input  logic                                 i_shift,
  output dw_pkg::word_t                        o_word
);

  dw_pkg::word_t [`DW_SLOTS-1:0] slot_q;
  dw_pkg::word_t [`DW_SLOTS-1:0] slot_sel;

  // Gather the picked members of this unit's column
  always_comb begin
    dw_pkg::member_idx_t src;
    logic                used;
    for (int s = 0; s < `DW_SLOTS; s++) begin
      src         = dw_pkg::slot_src(i_cfg, dw_pkg::slot_idx_t'(s), used);
      slot_sel[s] = used ? i_col[src] : '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      slot_q <= '0;
    end else if (i_load) begin
      slot_q <= slot_sel;
    end else if (i_shift) begin
      slot_q <= slot_q >> `DW_WORD_WIDTH;  // Next member drops into slot 0
    end
  end

  assign o_word = slot_q[0];

endmodule

// File: design/dw_shift_ctrl.sv
`timescale 1ns/1ps
`include "dw_defs.svh"

module dw_shift_ctrl (
  input  logic                   aclk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  logic                   i_last,
  input  logic [`DW_MEMBERS-1:0] i_keep,
  input  dw_pkg::cfg_e           i_cfg,
  input  logic                   i_m_ready,
  output logic                   o_s_ready,
  output logic                   o_valid,
  output logic                   o_last,
  output dw_pkg::cfg_e           o_cfg,
  output logic                   o_load,
  output logic                   o_shift
);

  dw_pkg::state_e       state_q;
  dw_pkg::state_e       state_d;
  dw_pkg::cfg_e         cfg_q;
  logic                 last_q;
  logic [`DW_SLOTS-1:0] keep_q;
  logic [`DW_SLOTS-1:0] keep_sel;
  logic                 next_kept;

  assign o_valid   = (state_q == dw_pkg::TX);
  assign o_load    = i_valid && o_s_ready;
  assign o_shift   = o_valid && i_m_ready;
  assign next_kept = keep_q[1];  // Slot that moves to the output next

  // While idle the lanes must select with the incoming code
  assign o_cfg = o_s_ready ? i_cfg : cfg_q;

  assign o_last = o_valid && last_q && !next_kept;

  // Keep bit of each picked member, in slot order
  always_comb begin
    dw_pkg::member_idx_t src;
    logic                used;
    for (int s = 0; s < `DW_SLOTS; s++) begin
      src         = dw_pkg::slot_src(i_cfg, dw_pkg::slot_idx_t'(s), used);
      keep_sel[s] = used && i_keep[src];
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      dw_pkg::RX: if (o_load) state_d = dw_pkg::TX;
      dw_pkg::TX: if (o_shift && !next_kept) state_d = dw_pkg::RX;  // Final kept member leaves
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      state_q   <= dw_pkg::RX;
      o_s_ready <= 1'b1;
      last_q    <= 1'b0;
      cfg_q     <= dw_pkg::K1S1;
      keep_q    <= '0;
    end else begin
      state_q   <= state_d;
      o_s_ready <= (state_d == dw_pkg::RX);
      if (o_load) begin
        last_q <= i_last;
        cfg_q  <= i_cfg;
        keep_q <= keep_sel;
      end else if (o_shift) begin
        keep_q <= keep_q >> 1;
      end
    end
  end

endmodule

// File: design/dw_pkg.sv
`include "dw_defs.svh"

package dw_pkg;

  typedef logic [`DW_WORD_WIDTH-1:0] word_t;
  typedef logic [`DW_MEMBER_BITS-1:0] member_idx_t;
  typedef logic [$clog2(`DW_SLOTS)-1:0] slot_idx_t;

  typedef enum logic [2:0] {
    K1S1  = 3'd0,
    K3S1  = 3'd1,
    K5S1  = 3'd2,
    K7S2  = 3'd3,
    K11S4 = 3'd4
  } cfg_e;

  typedef enum logic {
    RX = 1'b0,
    TX = 1'b1
  } state_e;

  // Source member of a slot. A member m is picked when m % j == j-1,
  // with j = kw + sw - 1. K1S1 only takes the last member.
  function automatic member_idx_t slot_src(input cfg_e cfg, input slot_idx_t slot,
                                           output logic used);
    int step;
    int idx;
    case (cfg)
      K3S1:    step = 3;
      K5S1:    step = 5;
      K7S2:    step = 8;
      K11S4:   step = 14;
      default: step = 0;  // K1S1 and unused codes
    endcase
    if (step == 0) begin
      idx = (slot == '0) ? `DW_MEMBERS - 1 : `DW_MEMBERS;
    end else begin
      idx = int'(slot) * step + step - 1;
    end
    used = (idx < `DW_MEMBERS);
    return used ? member_idx_t'(idx) : '0;
  endfunction

endpackage

// File: design/dw_defs.svh
`ifndef DW_DEFS_SVH
`define DW_DEFS_SVH

// Word geometry of one engine beat
`define DW_WORD_WIDTH 8
`define DW_UNITS 4
`define DW_MEMBERS 24

// Densest window (K3S1) picks every third member
`define DW_SLOTS (`DW_MEMBERS/3)

`define DW_MEMBER_BITS 5

`endif
